// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // Datapath widths
    localparam int XLEN       = 32;           // Data and address width
    localparam int XLEN_BYTES = XLEN / 8;     // Byte lanes per word
    localparam int REG_ADDR_W = 5;            // Destination register index

    // Input queue, sized to the upstream credit pool
    localparam int REQ_DEPTH = 4;
    localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);   // Holds 0..REQ_DEPTH

    // Write-back side credit pool
    localparam int DOWN_CREDITS = 2;
    localparam int CRED_W       = $clog2(DOWN_CREDITS + 1);

    // Data SRAM geometry
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);     // Word index is addr[DMEM_AW+1:2]

    // RV32I major opcodes that touch memory
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 of loads and stores
    localparam logic [2:0] F3_B  = 3'b000;    // LB / SB
    localparam logic [2:0] F3_H  = 3'b001;    // LH / SH
    localparam logic [2:0] F3_W  = 3'b010;    // LW / SW
    localparam logic [2:0] F3_BU = 3'b100;    // LBU
    localparam logic [2:0] F3_HU = 3'b101;    // LHU

    // Access size
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    // What the stage does with an operation
    typedef enum logic [1:0] {
        KIND_PASS  = 2'd0,    // Not a memory op, result goes straight through
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } lsu_kind_e;

endpackage

`default_nettype wire

// ==== hw/lsu/dmem_sram.sv ====
`default_nettype none

module dmem_sram import lsu_pkg::*; (
    input  wire                  clk,
    // Write port, byte masked
    input  wire                  we_i,
    input  wire [DMEM_AW-1:0]    widx_i,
    input  wire [XLEN_BYTES-1:0] wmask_i,
    input  wire [XLEN-1:0]       wdata_i,
    // Read port, one cycle latency
    input  wire [DMEM_AW-1:0]    ridx_i,
    output logic [XLEN-1:0]      rdata_o
);

    // Word array, contents undefined until written
    logic [XLEN-1:0] mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        for (int b = 0; b < XLEN_BYTES; b++) begin
            if (we_i && wmask_i[b])
                mem[widx_i][8*b +: 8] <= wdata_i[8*b +: 8];   // Only enabled lanes
        end
    end

    // Same-edge collision reads the old word
    always_ff @(posedge clk) begin
        rdata_o <= mem[ridx_i];
    end

endmodule

`default_nettype wire

// ==== hw/lsu/load_align.sv ====
`default_nettype none

module load_align import lsu_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    // From the issue stage registers
    input  wire                   s1_valid_i,
    input  wire lsu_kind_e        s1_kind_i,
    input  wire mem_size_e        s1_size_i,
    input  wire                   s1_unsigned_i,
    input  wire [1:0]             s1_byte_off_i,
    input  wire [XLEN-1:0]        s1_pc_i,
    input  wire [XLEN-1:0]        s1_inst_i,
    input  wire [XLEN-1:0]        s1_result_i,
    input  wire [REG_ADDR_W-1:0]  s1_rd_i,
    input  wire [XLEN-1:0]        rdata_i,      // SRAM word read at issue
    // To write-back
    output logic                  valid_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       inst_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [REG_ADDR_W-1:0] rd_o
);

    logic [XLEN-1:0] lane_word;   // Addressed lane moved down to bit 0
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;

    assign lane_word = rdata_i >> {s1_byte_off_i, 3'b000};

    always_comb begin
        case (s1_size_i)
            SIZE_B: begin
                if (s1_unsigned_i)
                    load_data = {{(XLEN-8){1'b0}}, lane_word[7:0]};
                else
                    load_data = {{(XLEN-8){lane_word[7]}}, lane_word[7:0]};
            end
            SIZE_H: begin
                if (s1_unsigned_i)
                    load_data = {{(XLEN-16){1'b0}}, lane_word[15:0]};
                else
                    load_data = {{(XLEN-16){lane_word[15]}}, lane_word[15:0]};
            end
            default: load_data = rdata_i;    // Full word
        endcase
    end

    // Stores and pass-through ops return the ALU result
    assign wb_data = (s1_kind_i == KIND_LOAD) ? load_data : s1_result_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= s1_valid_i;     // One pulse per result
    end

    always_ff @(posedge clk) begin
        if (s1_valid_i) begin
            pc_o      <= s1_pc_i;
            inst_o    <= s1_inst_i;
            wb_data_o <= wb_data;
            rd_o      <= s1_rd_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu/lsu_issue.sv ====
`default_nettype none

module lsu_issue import lsu_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    // Queue head
    input  wire                   q_valid_i,
    input  wire [XLEN-1:0]        q_pc_i,
    input  wire [XLEN-1:0]        q_inst_i,
    input  wire [XLEN-1:0]        q_result_i,
    input  wire [XLEN-1:0]        q_addr_i,
    input  wire [XLEN-1:0]        q_wdata_i,
    input  wire [REG_ADDR_W-1:0]  q_rd_i,
    input  wire                   credit_i,     // Write-back side returns a slot
    output logic                  q_pop_o,
    // SRAM ports
    output logic                  sram_we_o,
    output logic [DMEM_AW-1:0]    sram_widx_o,
    output logic [XLEN_BYTES-1:0] sram_wmask_o,
    output logic [XLEN-1:0]       sram_wdata_o,
    output logic [DMEM_AW-1:0]    sram_ridx_o,
    // Stage 1 register set
    output logic                  s1_valid_o,
    output lsu_kind_e             s1_kind_o,
    output mem_size_e             s1_size_o,
    output logic                  s1_unsigned_o,
    output logic [1:0]            s1_byte_off_o,
    output logic [XLEN-1:0]       s1_pc_o,
    output logic [XLEN-1:0]       s1_inst_o,
    output logic [XLEN-1:0]       s1_result_o,
    output logic [REG_ADDR_W-1:0] s1_rd_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    lsu_kind_e   kind;
    mem_size_e   size;
    logic        is_unsigned;
    logic [1:0]  byte_off;
    logic        issue;
    logic [CRED_W-1:0] cred_q;    // Free output slots

    assign opcode = q_inst_i[6:0];
    assign funct3 = q_inst_i[14:12];

    // Issue only with a reserved downstream slot
    assign issue   = q_valid_i && (cred_q != '0);
    assign q_pop_o = issue;

    always_comb begin
        if (opcode == OPC_LOAD)
            kind = KIND_LOAD;
        else if (opcode == OPC_STORE)
            kind = KIND_STORE;
        else
            kind = KIND_PASS;          // Everything else just flows through
        case (funct3)
            F3_B, F3_BU: size = SIZE_B;
            F3_H, F3_HU: size = SIZE_H;
            F3_W:        size = SIZE_W;
            default:     size = SIZE_W;
        endcase
        is_unsigned = (funct3 == F3_BU) || (funct3 == F3_HU);
        // Low address bits below the access size are dropped
        case (size)
            SIZE_B:  byte_off = q_addr_i[1:0];
            SIZE_H:  byte_off = {q_addr_i[1], 1'b0};
            default: byte_off = 2'b00;
        endcase
        // Replicate store data, the mask picks the lanes
        case (size)
            SIZE_B: begin
                sram_wmask_o = 4'b0001 << byte_off;
                sram_wdata_o = {4{q_wdata_i[7:0]}};
            end
            SIZE_H: begin
                sram_wmask_o = 4'b0011 << byte_off;
                sram_wdata_o = {2{q_wdata_i[15:0]}};
            end
            default: begin
                sram_wmask_o = 4'b1111;
                sram_wdata_o = q_wdata_i;
            end
        endcase
    end

    assign sram_we_o   = issue && (kind == KIND_STORE);   // Write lands at the issue edge
    assign sram_widx_o = q_addr_i[DMEM_AW+1:2];
    assign sram_ridx_o = q_addr_i[DMEM_AW+1:2];           // Read word registered at issue

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cred_q     <= CRED_W'(DOWN_CREDITS);
            s1_valid_o <= 1'b0;
        end else begin
            case ({issue, credit_i})
                2'b10:   cred_q <= cred_q - 1'b1;
                2'b01:   cred_q <= cred_q + 1'b1;
                default: cred_q <= cred_q;     // Both or neither cancel out
            endcase
            s1_valid_o <= issue;
        end
    end

    // Sideband travels with the op
    always_ff @(posedge clk) begin
        if (issue) begin
            s1_kind_o     <= kind;
            s1_size_o     <= size;
            s1_unsigned_o <= is_unsigned;
            s1_byte_off_o <= byte_off;
            s1_pc_o       <= q_pc_i;
            s1_inst_o     <= q_inst_i;
            s1_result_o   <= q_result_i;
            s1_rd_o       <= q_rd_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu/req_queue.sv ====
`default_nettype none

module req_queue import lsu_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    // Execute side, one entry per push
    input  wire                   push_i,
    input  wire [XLEN-1:0]        pc_i,
    input  wire [XLEN-1:0]        inst_i,
    input  wire [XLEN-1:0]        result_i,
    input  wire [XLEN-1:0]        addr_i,
    input  wire [XLEN-1:0]        wdata_i,
    input  wire [REG_ADDR_W-1:0]  rd_i,
    input  wire                   pop_i,
    // Head of queue
    output logic                  valid_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       inst_o,
    output logic [XLEN-1:0]       result_o,
    output logic [XLEN-1:0]       addr_o,
    output logic [XLEN-1:0]       wdata_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  credit_o     // One pulse per freed entry
);

    // Entry storage, no reset needed
    logic [XLEN-1:0]       pc_q     [REQ_DEPTH];
    logic [XLEN-1:0]       inst_q   [REQ_DEPTH];
    logic [XLEN-1:0]       result_q [REQ_DEPTH];
    logic [XLEN-1:0]       addr_q   [REQ_DEPTH];
    logic [XLEN-1:0]       wdata_q  [REQ_DEPTH];
    logic [REG_ADDR_W-1:0] rd_q     [REQ_DEPTH];

    logic [REQ_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [REQ_CNT_W-1:0] count_q;
    logic                 do_pop;

    assign do_pop = pop_i && valid_o;   // Ignore pops on an empty queue

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_q[wr_ptr_q]     <= pc_i;
            inst_q[wr_ptr_q]   <= inst_i;
            result_q[wr_ptr_q] <= result_i;
            addr_q[wr_ptr_q]   <= addr_i;
            wdata_q[wr_ptr_q]  <= wdata_i;
            rd_q[wr_ptr_q]     <= rd_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i)
                wr_ptr_q <= (wr_ptr_q == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= (rd_ptr_q == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push_i && !do_pop)
                count_q <= count_q + 1'b1;
            else if (!push_i && do_pop)
                count_q <= count_q - 1'b1;
            credit_o <= do_pop;          // Slot freed, hand the credit back
        end
    end

    // Head fields shown combinationally
    assign valid_o  = (count_q != '0);
    assign pc_o     = pc_q[rd_ptr_q];
    assign inst_o   = inst_q[rd_ptr_q];
    assign result_o = result_q[rd_ptr_q];
    assign addr_o   = addr_q[rd_ptr_q];
    assign wdata_o  = wdata_q[rd_ptr_q];
    assign rd_o     = rd_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    // Execute side
    input  wire                   valid_i,
    input  wire [XLEN-1:0]        pc_i,
    input  wire [XLEN-1:0]        inst_i,
    input  wire [XLEN-1:0]        result_i,
    input  wire [XLEN-1:0]        addr_i,
    input  wire [XLEN-1:0]        wdata_i,      // rs2 value
    input  wire [REG_ADDR_W-1:0]  rd_i,
    output logic                  credit_o,
    // Write-back side
    output logic                  valid_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       inst_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    input  wire                   credit_i
);

    // Queue head
    logic                  q_valid, q_pop;
    logic [XLEN-1:0]       q_pc, q_inst, q_result, q_addr, q_wdata;
    logic [REG_ADDR_W-1:0] q_rd;
    // SRAM links
    logic                  sram_we;
    logic [DMEM_AW-1:0]    sram_widx, sram_ridx;
    logic [XLEN_BYTES-1:0] sram_wmask;
    logic [XLEN-1:0]       sram_wdata, sram_rdata;
    // Issue to alignment
    logic                  s1_valid, s1_unsigned;
    lsu_kind_e             s1_kind;
    mem_size_e             s1_size;
    logic [1:0]            s1_byte_off;
    logic [XLEN-1:0]       s1_pc, s1_inst, s1_result;
    logic [REG_ADDR_W-1:0] s1_rd;

    req_queue req_queue_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .push_i(valid_i), .pc_i(pc_i), .inst_i(inst_i), .result_i(result_i),
        .addr_i(addr_i), .wdata_i(wdata_i), .rd_i(rd_i), .pop_i(q_pop),
        .valid_o(q_valid), .pc_o(q_pc), .inst_o(q_inst), .result_o(q_result),
        .addr_o(q_addr), .wdata_o(q_wdata), .rd_o(q_rd), .credit_o(credit_o)
    );

    lsu_issue lsu_issue_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .q_valid_i(q_valid), .q_pc_i(q_pc), .q_inst_i(q_inst), .q_result_i(q_result),
        .q_addr_i(q_addr), .q_wdata_i(q_wdata), .q_rd_i(q_rd), .credit_i(credit_i),
        .q_pop_o(q_pop),
        .sram_we_o(sram_we), .sram_widx_o(sram_widx), .sram_wmask_o(sram_wmask),
        .sram_wdata_o(sram_wdata), .sram_ridx_o(sram_ridx),
        .s1_valid_o(s1_valid), .s1_kind_o(s1_kind), .s1_size_o(s1_size),
        .s1_unsigned_o(s1_unsigned), .s1_byte_off_o(s1_byte_off), .s1_pc_o(s1_pc),
        .s1_inst_o(s1_inst), .s1_result_o(s1_result), .s1_rd_o(s1_rd)
    );

    dmem_sram dmem_sram_inst (
        .clk(clk), .we_i(sram_we), .widx_i(sram_widx), .wmask_i(sram_wmask),
        .wdata_i(sram_wdata), .ridx_i(sram_ridx), .rdata_o(sram_rdata)
    );

    load_align load_align_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .s1_valid_i(s1_valid), .s1_kind_i(s1_kind), .s1_size_i(s1_size),
        .s1_unsigned_i(s1_unsigned), .s1_byte_off_i(s1_byte_off), .s1_pc_i(s1_pc),
        .s1_inst_i(s1_inst), .s1_result_i(s1_result), .s1_rd_i(s1_rd),
        .rdata_i(sram_rdata),
        .valid_o(valid_o), .pc_o(pc_o), .inst_o(inst_o), .wb_data_o(wb_data_o),
        .rd_o(rd_o)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=lsu_sim
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module lsu_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG"
    exit 1
fi

exit 0

// ==== verif/lsu_tb.sv ====
`default_nettype none

module lsu_tb import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 100;
    localparam int          NUM_OPS      = 400;
    localparam int          WINDOW_WORDS = 64;          // Preloaded words hit by loads
    localparam logic [31:0] SEED         = 32'h62e6a093;
    localparam longint      TIMEOUT_NS   = longint'(NUM_OPS + WINDOW_WORDS) * 20 * CLK_PERIOD;

    logic                  clk, rst_n_i;
    logic                  valid_i, credit_i;
    logic [XLEN-1:0]       pc_i, inst_i, result_i, addr_i, wdata_i;
    logic [REG_ADDR_W-1:0] rd_i;
    logic                  credit_o, valid_o;
    logic [XLEN-1:0]       pc_o, inst_o, wb_data_o;
    logic [REG_ADDR_W-1:0] rd_o;

    // Reference model state
    logic [XLEN-1:0]       mem_model [DMEM_WORDS];
    logic [XLEN-1:0]       exp_pc[$], exp_inst[$], exp_wb[$];
    logic [REG_ADDR_W-1:0] exp_rd[$];
    int                    up_credits;      // Credits held by the sender
    int                    outstanding;     // Results seen but not yet credited
    int                    sent, delivered;
    int                    value_errors, proto_errors;
    logic [31:0]           stim_state, cred_state;

    lsu_top lsu_top_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .valid_i(valid_i), .pc_i(pc_i), .inst_i(inst_i), .result_i(result_i),
        .addr_i(addr_i), .wdata_i(wdata_i), .rd_i(rd_i), .credit_o(credit_o),
        .valid_o(valid_o), .pc_o(pc_o), .inst_o(inst_o), .wb_data_o(wb_data_o),
        .rd_o(rd_o), .credit_i(credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Separate streams so the two processes never share state
    function automatic logic [31:0] stim_rand();
        stim_state = lcg_next(stim_state);
        return stim_state ^ (stim_state >> 16);   // Fold the high half into the short-period low bits
    endfunction

    function automatic logic [31:0] credit_rand();
        cred_state = lcg_next(cred_state);
        return cred_state ^ (cred_state >> 16);
    endfunction

    // RV32I load result from a memory word
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] low,
                                               input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*low +: 8];
        h = low[1] ? word[31:16] : word[15:0];   // Bit 0 ignored for halves
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic store_merge(input logic [31:0] addr, input logic [2:0] f3,
                               input logic [31:0] wdata);
        logic [7:0] idx;
        idx = addr[9:2];
        case (f3)
            F3_B: mem_model[idx][8*addr[1:0] +: 8] = wdata[7:0];
            F3_H: begin
                if (addr[1])
                    mem_model[idx][31:16] = wdata[15:0];
                else
                    mem_model[idx][15:0] = wdata[15:0];
            end
            default: mem_model[idx] = wdata;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %08h, got %08h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // Entered and left at a rising edge plus 1 ns
    task automatic send_op(input logic [31:0] pc, input logic [31:0] inst,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] result);
        logic [31:0] wb;
        wb = result;                                  // Stores and pass-through
        if (inst[6:0] == OPC_STORE)
            store_merge(addr, inst[14:12], wdata);
        else if (inst[6:0] == OPC_LOAD)
            wb = load_value(mem_model[addr[9:2]], addr[1:0], inst[14:12]);
        while (up_credits == 0) begin
            @(posedge clk);
            #1;
        end
        valid_i  = 1'b1;
        pc_i     = pc;
        inst_i   = inst;
        addr_i   = addr;
        wdata_i  = wdata;
        result_i = result;
        rd_i     = inst[11:7];
        up_credits--;                                 // Spend one credit
        sent++;
        exp_pc.push_back(pc);
        exp_inst.push_back(inst);
        exp_wb.push_back(wb);
        exp_rd.push_back(inst[11:7]);
        @(posedge clk);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic send_random_op(input int n);
        logic [31:0] r_kind, r_addr, r_inst, wdata, result, addr;
        logic [6:0]  opc;
        logic [2:0]  f3;
        r_kind = stim_rand();
        r_addr = stim_rand();
        r_inst = stim_rand();
        wdata  = stim_rand();
        result = stim_rand();
        if (r_kind[31:24] < 8'd100) begin
            opc = OPC_LOAD;
            case (r_kind[23:16] % 5)
                0:       f3 = F3_B;
                1:       f3 = F3_H;
                2:       f3 = F3_W;
                3:       f3 = F3_BU;
                default: f3 = F3_HU;
            endcase
        end else if (r_kind[31:24] < 8'd190) begin
            opc = OPC_STORE;
            f3  = 3'(r_kind[23:16] % 3);             // SB, SH or SW
        end else begin
            case (r_kind[9:8])
                2'd0:    opc = 7'b0110011;            // OP
                2'd1:    opc = 7'b0010011;            // OP-IMM
                2'd2:    opc = 7'b0110111;            // LUI
                default: opc = 7'b1101111;            // JAL
            endcase
            f3 = r_kind[18:16];
        end
        // Word index stays in the window, upper address bits are noise
        addr = {r_addr[31:10], 2'b00, r_addr[25:20], r_addr[1:0]};
        send_op(32'h0000_1000 + 32'(n) * 32'd4, {r_inst[31:15], f3, r_inst[11:7], opc},
                addr, wdata, result);
    endtask

    // Upstream credits and result checking
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (credit_o) begin
                up_credits++;
                if (up_credits > REQ_DEPTH) begin
                    $display("Upstream credit returned with all %0d credits held at %0d ns",
                             REQ_DEPTH, $time);
                    proto_errors++;
                end
            end
            if (valid_o) begin
                if (exp_pc.size() == 0) begin
                    $display("Result delivered with no operation pending at %0d ns", $time);
                    proto_errors++;
                end else begin
                    check_value("pc_o", exp_pc.pop_front(), pc_o);
                    check_value("inst_o", exp_inst.pop_front(), inst_o);
                    check_value("wb_data_o", exp_wb.pop_front(), wb_data_o);
                    check_value("rd_o", 32'(exp_rd.pop_front()), 32'(rd_o));
                end
                delivered++;
                outstanding++;
                if (outstanding > DOWN_CREDITS) begin
                    $display("More results in flight than downstream credits at %0d ns", $time);
                    proto_errors++;
                end
            end
        end
    end

    // Write-back side hands credits back after random, sometimes long, delays
    initial begin
        int          hold;
        logic [31:0] r;
        hold = 0;
        @(posedge rst_n_i);
        forever begin
            @(posedge clk);
            #1;
            credit_i = 1'b0;
            if (outstanding > 0) begin
                if (hold > 0) begin
                    hold--;
                end else begin
                    credit_i = 1'b1;
                    outstanding--;
                    r = credit_rand();
                    if (r[31:28] == 4'd0)
                        hold = 16 + int'(r[20:16]);   // Long stall
                    else
                        hold = int'(r[17:16]);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout, %0d of %0d operations delivered", delivered, sent);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        credit_i     = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        result_i     = '0;
        addr_i       = '0;
        wdata_i      = '0;
        rd_i         = '0;
        up_credits   = REQ_DEPTH;
        outstanding  = 0;
        sent         = 0;
        delivered    = 0;
        value_errors = 0;
        proto_errors = 0;
        stim_state   = SEED;
        cred_state   = lcg_next(~SEED);
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        // SW to every window word so no load sees undefined SRAM
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            r = stim_rand();
            send_op(32'h0000_0800 + 32'(w) * 32'd4, {17'h0, F3_W, 5'd0, OPC_STORE},
                    32'(w) * 32'd4, r, ~r);
        end
        for (int n = 0; n < NUM_OPS; n++) begin
            send_random_op(n);
            r = stim_rand();
            if (r[31:30] == 2'd0) begin
                repeat (1 + int'(r[26:24])) begin        // Idle gap upstream
                    @(posedge clk);
                    #1;
                end
            end
        end
        while (exp_pc.size() != 0 || outstanding != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (up_credits != REQ_DEPTH) begin
            $display("Only %0d of %0d upstream credits returned after drain",
                     up_credits, REQ_DEPTH);
            proto_errors++;
        end
        if (delivered != sent) begin
            $display("Sent %0d operations but %0d results came back", sent, delivered);
            proto_errors++;
        end
        $display("Checked %0d results, value errors %0d, protocol errors %0d",
                 delivered, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/lsu_pkg.sv
hw/lsu/req_queue.sv
hw/lsu/lsu_issue.sv
hw/lsu/dmem_sram.sv
hw/lsu/load_align.sv
hw/lsu_top.sv
verif/lsu_tb.sv
